// ==== corePkg.sv ====
package corePkg;

	// Datapath widths
	localparam int wordWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int imemDepth = 64;
	localparam int dmemDepth = 64;

	typedef logic [wordWidth-1:0] wordT;
	typedef logic [regAddrWidth-1:0] regAddrT;
	// Word index into instruction memory
	typedef logic [$clog2(imemDepth)-1:0] pcT;
	// Word index into data memory
	typedef logic [$clog2(dmemDepth)-1:0] dAddrT;
	typedef logic [2:0] aluOpT;
	typedef logic [1:0] fwdSelT;

	// --------------------
	// Opcode field
	localparam logic [5:0] opRType = 6'h00;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opSw = 6'h2b;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opHalt = 6'h3f;

	// Function field of R-type
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2a;

	// --------------------
	// ALU operations
	localparam aluOpT aluAdd = 3'd0;
	localparam aluOpT aluSub = 3'd1;
	localparam aluOpT aluAnd = 3'd2;
	localparam aluOpT aluOr = 3'd3;
	localparam aluOpT aluSlt = 3'd4;

	// Operand sources
	localparam fwdSelT fwdRegFile = 2'd0;
	localparam fwdSelT fwdMemStage = 2'd1;
	localparam fwdSelT fwdWbStage = 2'd2;

	// Run handshake states
	typedef enum logic [1:0] {runIdle, runRunning, runDraining, runDone} runStateT;

endpackage

// ==== instrMem.sv ====
`timescale 1ns/1ps

module instrMem
(
	input logic clk,
	input logic we,
	input corePkg::pcT wAddr,
	input corePkg::wordT wData,
	input corePkg::pcT rAddr,
	output corePkg::wordT rData
);

	import corePkg::*;

	// Program storage, one instruction per word
	wordT mem [imemDepth];

	// Host load port
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[wAddr] <= wData;
		end
	end

	// Fetch reads without a clock
	assign rData = mem[rAddr];

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile
(
	input logic clk,
	input logic rstN,
	input corePkg::regAddrT rAddrA,
	input corePkg::regAddrT rAddrB,
	output corePkg::wordT rDataA,
	output corePkg::wordT rDataB,
	input logic we,
	input corePkg::regAddrT wAddr,
	input corePkg::wordT wData
);

	import corePkg::*;

	// Registers 1 to 31, register zero has no storage
	wordT regs [1:31];
	logic writeLive;

	assign writeLive = we && (wAddr != '0);

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			for (int i = 1; i < 32; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (writeLive)
		begin
			regs[wAddr] <= wData;
		end
	end

	// Write-through so decode sees the value retiring this cycle
	assign rDataA = (rAddrA == '0) ? '0 :
		(writeLive && wAddr == rAddrA) ? wData : regs[rAddrA];
	assign rDataB = (rAddrB == '0) ? '0 :
		(writeLive && wAddr == rAddrB) ? wData : regs[rAddrB];

endmodule

// ==== controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit
(
	input logic [5:0] opcode,
	input logic [5:0] funct,
	output logic regWrite,
	output logic memToReg,
	output logic memWrite,
	output logic aluSrcImm,
	output logic regDst,
	output logic branch,
	output logic halt,
	output corePkg::aluOpT aluOp
);

	import corePkg::*;

	always_comb
	begin
		// Default is a no-op with nothing written
		regWrite = 1'b0;
		memToReg = 1'b0;
		memWrite = 1'b0;
		aluSrcImm = 1'b0;
		regDst = 1'b0;
		branch = 1'b0;
		halt = 1'b0;
		aluOp = aluAdd;
		case (opcode)
			opRType:
			begin
				// Only the kept functions write rd
				regDst = 1'b1;
				case (funct)
					fnAdd: {regWrite, aluOp} = {1'b1, aluAdd};
					fnSub: {regWrite, aluOp} = {1'b1, aluSub};
					fnAnd: {regWrite, aluOp} = {1'b1, aluAnd};
					fnOr: {regWrite, aluOp} = {1'b1, aluOr};
					fnSlt: {regWrite, aluOp} = {1'b1, aluSlt};
					default: regWrite = 1'b0;
				endcase
			end
			opAddi:
			begin
				regWrite = 1'b1;
				aluSrcImm = 1'b1;
			end
			opLw:
			begin
				// Address is base plus offset
				regWrite = 1'b1;
				memToReg = 1'b1;
				aluSrcImm = 1'b1;
			end
			opSw:
			begin
				memWrite = 1'b1;
				aluSrcImm = 1'b1;
			end
			opBeq:
			begin
				// Compare happens in decode
				branch = 1'b1;
				aluOp = aluSub;
			end
			opHalt: halt = 1'b1;
			default: halt = 1'b0;
		endcase
	end

endmodule

// ==== forwardUnit.sv ====
`timescale 1ns/1ps

module forwardUnit
(
	input corePkg::regAddrT rsDecode,
	input corePkg::regAddrT rtDecode,
	input corePkg::regAddrT rsExec,
	input corePkg::regAddrT rtExec,
	input corePkg::regAddrT writeRegMem,
	input corePkg::regAddrT writeRegWb,
	input logic regWriteMem,
	input logic regWriteWb,
	output corePkg::fwdSelT fwdADecode,
	output corePkg::fwdSelT fwdBDecode,
	output corePkg::fwdSelT fwdAExec,
	output corePkg::fwdSelT fwdBExec
);

	import corePkg::*;

	// Newest producer wins, register zero never forwards
	function automatic fwdSelT selectSrc(input regAddrT src, input logic allowWb);
		if (regWriteMem && writeRegMem != '0 && writeRegMem == src)
		begin
			return fwdMemStage;
		end
		if (allowWb && regWriteWb && writeRegWb != '0 && writeRegWb == src)
		begin
			return fwdWbStage;
		end
		return fwdRegFile;
	endfunction

	// Comparator in decode
	// Write-back already reaches it through the register file
	assign fwdADecode = selectSrc(rsDecode, 1'b0);
	assign fwdBDecode = selectSrc(rtDecode, 1'b0);

	// ALU operands in execute
	assign fwdAExec = selectSrc(rsExec, 1'b1);
	assign fwdBExec = selectSrc(rtExec, 1'b1);

endmodule

// ==== hazardUnit.sv ====
`timescale 1ns/1ps

module hazardUnit
(
	input corePkg::regAddrT rsDecode,
	input corePkg::regAddrT rtDecode,
	input corePkg::regAddrT rtExec,
	input corePkg::regAddrT writeRegExec,
	input corePkg::regAddrT writeRegMem,
	input logic branchDecode,
	input logic memToRegExec,
	input logic memToRegMem,
	input logic regWriteExec,
	output logic stallFetch,
	output logic stallDecode,
	output logic flushExec
);

	logic loadUseStall;
	logic branchStall;

	// Load in execute, its data arrives one cycle too late
	assign loadUseStall = memToRegExec && (rtExec != '0) &&
		(rtExec == rsDecode || rtExec == rtDecode);

	// beq needs its operands in decode
	// ALU result still in execute, or load data still in memory
	assign branchStall = branchDecode && (
		(regWriteExec && writeRegExec != '0 &&
			(writeRegExec == rsDecode || writeRegExec == rtDecode)) ||
		(memToRegMem && writeRegMem != '0 &&
			(writeRegMem == rsDecode || writeRegMem == rtDecode)));

	// Hold fetch and decode, insert a bubble into execute
	assign stallFetch = loadUseStall || branchStall;
	assign stallDecode = loadUseStall || branchStall;
	assign flushExec = loadUseStall || branchStall;

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps

module alu
(
	input corePkg::wordT a,
	input corePkg::wordT b,
	input corePkg::aluOpT op,
	output corePkg::wordT y
);

	import corePkg::*;

	always_comb
	begin
		case (op)
			aluAdd: y = a + b;
			aluSub: y = a - b;
			aluAnd: y = a & b;
			aluOr: y = a | b;
			// Signed compare, result in bit 0
			aluSlt: y = wordT'($signed(a) < $signed(b));
			default: y = '0;
		endcase
	end

endmodule

// ==== dataMem.sv ====
`timescale 1ns/1ps

module dataMem
(
	input logic clk,
	input logic we,
	input corePkg::dAddrT addr,
	input corePkg::wordT wData,
	output corePkg::wordT rData
);

	import corePkg::*;

	// Contents survive reset and carry over between runs
	wordT mem [dmemDepth];

	// Store lands on the clock edge
	always_ff @(posedge clk)
	begin
		if (we)
		begin
			mem[addr] <= wData;
		end
	end

	// Load data is ready in the same cycle
	assign rData = mem[addr];

endmodule

// ==== pipeCore.sv ====
`timescale 1ns/1ps

module pipeCore
(
	input logic clk,
	input logic rstN,
	input logic req,
	output logic ack,
	input logic imemWe,
	input corePkg::pcT imemAddr,
	input corePkg::wordT imemData,
	output logic wbValid,
	output corePkg::regAddrT wbReg,
	output corePkg::wordT wbData
);

	import corePkg::*;

	// Run control
	runStateT state;
	logic reqQ, startRun, fetchActive;
	// Fetch
	pcT pcF, pcPlus1F;
	wordT instrF;
	// Decode
	wordT instrD, rd1D, rd2D, signImmD, cmpA, cmpB;
	pcT pcPlus1D, pcBranchD;
	logic regWriteD, memToRegD, memWriteD, aluSrcImmD, regDstD, branchD, haltD;
	logic branchTaken;
	aluOpT aluOpD;
	// Execute
	logic regWriteE, memToRegE, memWriteE, aluSrcImmE, regDstE, haltE;
	aluOpT aluOpE;
	wordT rd1E, rd2E, signImmE, srcAE, writeDataE, srcBE, aluOutE;
	regAddrT rsE, rtE, rdE, writeRegE;
	// Memory
	logic regWriteM, memToRegM, memWriteM, haltM;
	wordT aluOutM, writeDataM, readDataM;
	regAddrT writeRegM;
	// Write-back
	logic regWriteW, memToRegW, haltW;
	wordT aluOutW, readDataW, resultW;
	regAddrT writeRegW;
	// Hazard and forwarding
	fwdSelT fwdADecode, fwdBDecode, fwdAExec, fwdBExec;
	logic stallFetch, stallDecode, flushExec;

	// --------------------
	// Run handshake FSM
	assign startRun = (state == runIdle) && req && !reqQ;
	assign ack = (state == runDone);

	always_ff @(posedge clk)
	begin
		if (!rstN)
		begin
			state <= runIdle;
			reqQ <= 1'b0;
		end
		else
		begin
			reqQ <= req;
			case (state)
				runIdle: if (startRun) state <= runRunning;
				// Halt in decode ends fetching
				runRunning: if (haltD && !stallDecode) state <= runDraining;
				runDraining: if (haltW) state <= runDone;
				runDone: if (!req) state <= runIdle;
				default: state <= runIdle;
			endcase
		end
	end

	// --------------------
	// Fetch
	assign fetchActive = (state == runRunning) && !haltD;
	assign pcPlus1F = pcF + pcT'(1);

	always_ff @(posedge clk)
	begin
		if (!rstN || startRun)
			pcF <= '0;
		else if (fetchActive && !stallFetch)
			pcF <= branchTaken ? pcBranchD : pcPlus1F;
	end

	instrMem instrMem_i (.clk(clk), .we(imemWe), .wAddr(imemAddr), .wData(imemData),
		.rAddr(pcF), .rData(instrF));

	// IF/ID, a zero word decodes as a bubble
	always_ff @(posedge clk)
	begin
		if (!rstN || startRun)
			instrD <= '0;
		else if (!stallDecode)
			instrD <= (branchTaken || !fetchActive) ? '0 : instrF;
	end

	always_ff @(posedge clk)
	begin
		if (!stallDecode)
			pcPlus1D <= pcPlus1F;
	end

	// --------------------
	// Decode
	controlUnit controlUnit_i (.opcode(instrD[31:26]), .funct(instrD[5:0]),
		.regWrite(regWriteD), .memToReg(memToRegD), .memWrite(memWriteD),
		.aluSrcImm(aluSrcImmD), .regDst(regDstD), .branch(branchD), .halt(haltD),
		.aluOp(aluOpD));

	regFile regFile_i (.clk(clk), .rstN(rstN), .rAddrA(instrD[25:21]),
		.rAddrB(instrD[20:16]), .rDataA(rd1D), .rDataB(rd2D), .we(regWriteW),
		.wAddr(writeRegW), .wData(resultW));

	assign signImmD = {{16{instrD[15]}}, instrD[15:0]};
	// Word offset relative to the next instruction
	assign pcBranchD = pcPlus1D + signImmD[5:0];

	// Equality test on forwarded operands
	assign cmpA = (fwdADecode == fwdMemStage) ? aluOutM : rd1D;
	assign cmpB = (fwdBDecode == fwdMemStage) ? aluOutM : rd2D;
	// A stalled beq still waits for its operands
	assign branchTaken = branchD && (cmpA == cmpB) && !stallDecode;

	// ID/EX control, cleared for a bubble
	always_ff @(posedge clk)
	begin
		if (!rstN || startRun || flushExec)
			{regWriteE, memToRegE, memWriteE, haltE} <= '0;
		else
			{regWriteE, memToRegE, memWriteE, haltE} <= {regWriteD, memToRegD, memWriteD, haltD};
	end

	always_ff @(posedge clk)
	begin
		{aluSrcImmE, regDstE, aluOpE} <= {aluSrcImmD, regDstD, aluOpD};
		{rd1E, rd2E, signImmE} <= {rd1D, rd2D, signImmD};
		{rsE, rtE, rdE} <= instrD[25:11];
	end

	// --------------------
	// Execute
	assign writeRegE = regDstE ? rdE : rtE;

	always_comb
	begin
		case (fwdAExec)
			fwdMemStage: srcAE = aluOutM;
			fwdWbStage: srcAE = resultW;
			default: srcAE = rd1E;
		endcase
		case (fwdBExec)
			fwdMemStage: writeDataE = aluOutM;
			fwdWbStage: writeDataE = resultW;
			default: writeDataE = rd2E;
		endcase
	end

	assign srcBE = aluSrcImmE ? signImmE : writeDataE;

	alu alu_i (.a(srcAE), .b(srcBE), .op(aluOpE), .y(aluOutE));

	// EX/MEM
	always_ff @(posedge clk)
	begin
		if (!rstN || startRun)
			{regWriteM, memToRegM, memWriteM, haltM} <= '0;
		else
			{regWriteM, memToRegM, memWriteM, haltM} <= {regWriteE, memToRegE, memWriteE, haltE};
	end

	always_ff @(posedge clk)
	begin
		{aluOutM, writeDataM, writeRegM} <= {aluOutE, writeDataE, writeRegE};
	end

	// --------------------
	// Memory, byte offset dropped
	dataMem dataMem_i (.clk(clk), .we(memWriteM), .addr(aluOutM[7:2]),
		.wData(writeDataM), .rData(readDataM));

	// MEM/WB
	always_ff @(posedge clk)
	begin
		if (!rstN || startRun)
			{regWriteW, memToRegW, haltW} <= '0;
		else
			{regWriteW, memToRegW, haltW} <= {regWriteM, memToRegM, haltM};
	end

	always_ff @(posedge clk)
	begin
		{aluOutW, readDataW, writeRegW} <= {aluOutM, readDataM, writeRegM};
	end

	// --------------------
	// Write-back and observation port
	assign resultW = memToRegW ? readDataW : aluOutW;
	assign wbValid = regWriteW && (writeRegW != '0);
	assign wbReg = writeRegW;
	assign wbData = resultW;

	// --------------------
	// Hazard detection and forwarding side by side
	forwardUnit forwardUnit_i (.rsDecode(instrD[25:21]), .rtDecode(instrD[20:16]),
		.rsExec(rsE), .rtExec(rtE), .writeRegMem(writeRegM), .writeRegWb(writeRegW),
		.regWriteMem(regWriteM), .regWriteWb(regWriteW), .fwdADecode(fwdADecode),
		.fwdBDecode(fwdBDecode), .fwdAExec(fwdAExec), .fwdBExec(fwdBExec));

	hazardUnit hazardUnit_i (.rsDecode(instrD[25:21]), .rtDecode(instrD[20:16]),
		.rtExec(rtE), .writeRegExec(writeRegE), .writeRegMem(writeRegM),
		.branchDecode(branchD), .memToRegExec(memToRegE), .memToRegMem(memToRegM),
		.regWriteExec(regWriteE), .stallFetch(stallFetch), .stallDecode(stallDecode),
		.flushExec(flushExec));

endmodule

// ==== pipeCore_props.sv ====
`timescale 1ns/1ps

module pipeCoreProps
(
	input logic clk,
	input logic rstN,
	input logic req,
	input logic ack,
	input logic wbValid,
	input corePkg::regAddrT wbReg,
	input corePkg::runStateT state,
	input logic stallFetch,
	input logic regWriteE,
	input logic memToRegE,
	input logic memWriteE,
	input logic haltE
);

	import corePkg::*;

	// --------------------
	// Run handshake
	// ack drops only once the host has dropped req
	ackFallsAfterReq: assert property (@(posedge clk) disable iff (!rstN)
		$fell(ack) |-> !$past(req))
		else $error("ack fell while req was still high");

	// ack held for as long as req stays high
	ackHeldWithReq: assert property (@(posedge clk) disable iff (!rstN)
		(ack && req) |=> ack)
		else $error("ack dropped while req was high");

	// Idle core is empty, no ack and nothing retiring
	ackLowInIdle: assert property (@(posedge clk) disable iff (!rstN)
		(state == runIdle) |-> (!ack && !wbValid))
		else $error("ack or write-back seen in idle state");

	// --------------------
	// Pipeline control
	// Register zero never shows on the port
	noWbToZero: assert property (@(posedge clk) disable iff (!rstN)
		wbValid |-> (wbReg != '0))
		else $error("write-back reported for register zero");

	// A held fetch leaves a bubble in execute
	stallFlushTogether: assert property (@(posedge clk) disable iff (!rstN)
		stallFetch |=> !(regWriteE || memToRegE || memWriteE || haltE))
		else $error("fetch stalled without a bubble in execute");

endmodule

// ==== pipeCoreTb.sv ====
`timescale 1ns/1ps

module pipeCoreTb;

	import corePkg::*;

	localparam int runCount = 8;
	localparam int idleTimeout = 200;
	localparam int ackTimeout = 10;
	localparam int dataWords = 8;
	localparam logic [5:0] fnList [5] = '{fnAdd, fnSub, fnAnd, fnOr, fnSlt};

	logic clk;
	logic rstN;
	logic req;
	logic ack;
	logic imemWe;
	pcT imemAddr;
	wordT imemData;
	logic wbValid;
	regAddrT wbReg;
	wordT wbData;

	// Program image and reference state
	wordT prog [imemDepth];
	int progLen;
	wordT modelRegs [8];
	wordT modelMem [dmemDepth];
	regAddrT expReg [$];
	wordT expData [$];
	int expCount;

	integer seed;
	int mismatchCount;
	int failCount;
	int wbCount;
	logic timedOut;

	pipeCore pipeCore_i (.clk(clk), .rstN(rstN), .req(req), .ack(ack), .imemWe(imemWe),
		.imemAddr(imemAddr), .imemData(imemData), .wbValid(wbValid), .wbReg(wbReg),
		.wbData(wbData));

	bind pipeCore pipeCoreProps pipeCoreProps_i (.clk(clk), .rstN(rstN), .req(req),
		.ack(ack), .wbValid(wbValid), .wbReg(wbReg), .state(state),
		.stallFetch(stallFetch), .regWriteE(regWriteE), .memToRegE(memToRegE),
		.memWriteE(memWriteE), .haltE(haltE));

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// --------------------
	// Program generator
	function automatic int pick(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic wordT encI(input logic [5:0] op, input int rt, input int rs, input int imm);
		return {op, 5'(rs), 5'(rt), 16'(imm)};
	endfunction

	task automatic makeProgram(input int runIdx);
		int idx;
		int haltIdx;
		int kind;
		int maxOff;
		int rs;
		idx = 0;
		// First run clears the data words that loads may touch
		if (runIdx == 0)
		begin
			for (int a = 0; a < dataWords; a++)
			begin
				prog[idx] = encI(opSw, 0, 0, 4 * a);
				idx++;
			end
		end
		haltIdx = idx + 23 + pick(17);
		for (int i = idx; i < haltIdx; i++)
		begin
			kind = pick(10);
			maxOff = haltIdx - i - 1;
			// beq right before halt has no legal target
			if (kind >= 8 && maxOff < 1)
				kind = 5;
			if (kind <= 4)
				prog[i] = {opRType, 5'(pick(8)), 5'(pick(8)), 5'(pick(8)), 5'd0, fnList[pick(5)]};
			else if (kind == 5)
				prog[i] = encI(opAddi, pick(8), pick(8), pick(16) - 4);
			else if (kind == 6)
				prog[i] = encI(opLw, pick(8), 0, 4 * pick(dataWords));
			else if (kind == 7)
				prog[i] = encI(opSw, pick(8), 0, 4 * pick(dataWords));
			else
			begin
				// Equal operands now and then, for more taken branches
				rs = pick(8);
				prog[i] = encI(opBeq, (pick(3) == 0) ? rs : pick(8), rs,
					1 + pick((maxOff < 3) ? maxOff : 3));
			end
		end
		prog[haltIdx] = {opHalt, 26'd0};
		progLen = haltIdx + 1;
	endtask

	// --------------------
	// Instruction-set model
	task automatic modelWrite(input int r, input wordT v);
		if (r != 0)
		begin
			modelRegs[r] = v;
			expReg.push_back(regAddrT'(r));
			expData.push_back(v);
		end
	endtask

	task automatic runModel();
		int pc;
		wordT ins;
		wordT a;
		wordT b;
		wordT imm;
		wordT addr;
		pc = 0;
		expReg.delete();
		expData.delete();
		while (pc < progLen && prog[pc][31:26] != opHalt)
		begin
			ins = prog[pc];
			a = modelRegs[ins[23:21]];
			b = modelRegs[ins[18:16]];
			imm = {{16{ins[15]}}, ins[15:0]};
			addr = a + imm;
			pc++;
			case (ins[31:26])
				opRType:
				begin
					case (ins[5:0])
						fnAdd: modelWrite(ins[15:11], a + b);
						fnSub: modelWrite(ins[15:11], a - b);
						fnAnd: modelWrite(ins[15:11], a & b);
						fnOr: modelWrite(ins[15:11], a | b);
						default: modelWrite(ins[15:11], ($signed(a) < $signed(b)) ? 1 : 0);
					endcase
				end
				opAddi: modelWrite(ins[20:16], a + imm);
				// Word index from address bits 7 to 2
				opLw: modelWrite(ins[20:16], modelMem[addr[7:2]]);
				opSw: modelMem[addr[7:2]] = b;
				opBeq: if (a == b) pc += int'($signed(imm));
				default: pc = pc;
			endcase
		end
		expCount = expReg.size();
	endtask

	// --------------------
	// Host side
	task automatic loadProgram();
		for (int i = 0; i < progLen; i++)
		begin
			@(posedge clk);
			imemWe <= 1'b1;
			imemAddr <= pcT'(i);
			imemData <= prog[i];
		end
		@(posedge clk);
		imemWe <= 1'b0;
	endtask

	task automatic checkIdle(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			assert (ack === 1'b0) else
			begin
				failCount++;
				$display("ack is high at %0t while the core is idle", $time);
			end
			assert (wbValid === 1'b0) else
			begin
				failCount++;
				$display("Write-back seen at %0t while the core is idle", $time);
			end
		end
	endtask

	task automatic checkRetire();
		regAddrT er;
		wordT ed;
		wbCount++;
		assert (expReg.size() > 0) else
		begin
			failCount++;
			$display("Extra write-back at %0t to register %0d", $time, wbReg);
		end
		if (expReg.size() > 0)
		begin
			er = expReg.pop_front();
			ed = expData.pop_front();
			assert (wbReg == er) else
			begin
				mismatchCount++;
				$display("Mismatch at %0t: wbReg expected %0d got %0d", $time, er, wbReg);
			end
			assert (wbData == ed) else
			begin
				mismatchCount++;
				$display("Mismatch at %0t: wbData expected %h got %h", $time, ed, wbData);
			end
		end
	endtask

	task automatic runProgram();
		int quiet;
		@(posedge clk);
		req <= 1'b1;
		wbCount = 0;
		quiet = 0;
		// Timeout restarts at every retired write
		while (ack !== 1'b1 && !timedOut)
		begin
			@(negedge clk);
			if (wbValid === 1'b1)
			begin
				checkRetire();
				quiet = 0;
			end
			else
				quiet++;
			if (quiet > idleTimeout)
			begin
				timedOut = 1'b1;
				failCount++;
				$display("Timeout at %0t: no write-back or ack for %0d cycles", $time, quiet);
			end
		end
		if (!timedOut)
		begin
			assert (wbCount == expCount) else
			begin
				mismatchCount++;
				$display("Mismatch at %0t: write-back count expected %0d got %0d", $time,
					expCount, wbCount);
			end
		end
	endtask

	task automatic endHandshake();
		int waitCycles;
		// ack holds while req stays high
		repeat (3)
		begin
			@(negedge clk);
			assert (ack === 1'b1) else
			begin
				failCount++;
				$display("ack dropped at %0t while req was still high", $time);
			end
			assert (wbValid === 1'b0) else
			begin
				failCount++;
				$display("Write-back seen at %0t after ack", $time);
			end
		end
		@(posedge clk);
		req <= 1'b0;
		waitCycles = 0;
		while (ack === 1'b1 && !timedOut)
		begin
			@(negedge clk);
			waitCycles++;
			if (waitCycles > ackTimeout)
			begin
				timedOut = 1'b1;
				failCount++;
				$display("Timeout at %0t: ack stayed high after req dropped", $time);
			end
		end
	endtask

	// --------------------
	// Main sequence
	initial
	begin
		seed = 32'h9b82_13d4;
		mismatchCount = 0;
		failCount = 0;
		timedOut = 1'b0;
		rstN = 1'b0;
		req = 1'b0;
		imemWe = 1'b0;
		imemAddr = '0;
		imemData = '0;
		for (int i = 0; i < 8; i++)
			modelRegs[i] = '0;
		for (int i = 0; i < dmemDepth; i++)
			modelMem[i] = '0;
		repeat (10) @(posedge clk);
		rstN <= 1'b1;
		checkIdle(8);
		// Data memory and registers carry over from run to run
		for (int r = 0; r < runCount && !timedOut; r++)
		begin
			makeProgram(r);
			runModel();
			loadProgram();
			checkIdle(2);
			runProgram();
			if (!timedOut)
				endHandshake();
		end
		$display("Errors: %0d value mismatches, %0d other failures", mismatchCount, failCount);
		if (mismatchCount == 0 && failCount == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== list.f ====
corePkg.sv
instrMem.sv
regFile.sv
controlUnit.sv
forwardUnit.sv
hazardUnit.sv
alu.sv
dataMem.sv
pipeCore.sv
pipeCore_props.sv
pipeCoreTb.sv

// ==== Bender.yml ====
package:
  name: pipecore

sources:
  - corePkg.sv
  - instrMem.sv
  - regFile.sv
  - controlUnit.sv
  - forwardUnit.sv
  - hazardUnit.sv
  - alu.sv
  - dataMem.sv
  - pipeCore.sv
  - target: test
    files:
      - pipeCore_props.sv
      - pipeCoreTb.sv
